//--- src/me_params.svh
/*
 * Geometry of the reference buffer and the horizontal search.
 * Include wherever block, bank or search sizes are needed.
 */

`ifndef ME_PARAMS_SVH
`define ME_PARAMS_SVH

// --------------------------------------------------
// Reference buffer
// --------------------------------------------------
// Blocks in one reference line, small for simulation
`define ME_BLOCKS_PER_LINE 6
// Words per block, one block per bank
`define ME_SRAM_DEPTH 23
// Address count at which the next current block is requested
`define ME_NEXT_BLOCK_OFFSET 8

// --------------------------------------------------
// Search
// --------------------------------------------------
`define ME_SEARCH_RANGE 16
`define ME_BLOCK_ROWS 8

`endif

//--- src/me_pkg.sv
/*
 * Shared types of the motion-estimation slice.
 * Import in the module body, use scoped names in port lists.
 */

`default_nettype none

package me_pkg;

    typedef logic [7:0] pixel_t;

    // Element 0 is the most significant pixel
    typedef pixel_t [0:7] ref_word_t;

    typedef struct packed {
        logic          valid;
        logic [4:0]    row;
        pixel_t [0:22] pixels;
    } ref_window_t;

    typedef logic [13:0] sad_t;

    typedef struct packed {
        logic [3:0] best_dx;
        sad_t       min_sad;
        logic       done;
    } sad_result_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [4:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {FILL, RUN, LINE_GAP} buf_state_e;

endpackage

`default_nettype wire

//--- src/ref_sram_bank.sv
/*
 * Single-port synchronous RAM, 24 x 64, standing in for the memory macro.
 * One access per enabled cycle, either a write or a registered read.
 */

`timescale 1ns/10ps
`default_nettype none

`include "me_params.svh"

module ref_sram_bank (
    input  logic              clk,
    input  logic              me,
    input  logic              we,
    input  logic [4:0]        adr,
    input  me_pkg::ref_word_t d,
    output me_pkg::ref_word_t q
);

    import me_pkg::*;

    // One spare word above the block depth, as in the macro
    ref_word_t mem [0:`ME_SRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (me) begin
            if (we) begin
                mem[adr] <= d;
            end else begin
                q <= mem[adr];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ref_window_buffer.sv
/*
 * Rotating four-bank reference store. Each block of 23 words goes to the
 * next bank; the three older banks form a 23-pixel window row per cycle.
 * Also flags when windows are valid and when a new current block is due.
 */

`timescale 1ns/10ps
`default_nettype none

`include "me_params.svh"

module ref_window_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  me_pkg::ref_word_t   ref_in,
    output me_pkg::ref_window_t window,
    output logic                sram_ready,
    output logic                next_block
);

    import me_pkg::*;

    logic [4:0] addr_cnt;
    logic [4:0] addr;
    logic [4:0] rd_row;
    ref_word_t  wr_data;
    logic [3:0] written;
    logic [3:0] rd_sel;
    logic [7:0] block_cnt;
    buf_state_e state;
    logic       next_line;
    logic       next_block_q;
    logic       block_end;
    ref_word_t  q [4];

    // --------------------------------------------------
    // Address and write data, shared by all banks
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_cnt <= '0;
            addr     <= '0;
            rd_row   <= '0;
        end else if (en) begin
            addr_cnt <= (addr_cnt == `ME_SRAM_DEPTH - 1) ? '0 : addr_cnt + 5'd1;
            addr     <= addr_cnt;
            // Index of the row the banks return next
            rd_row   <= addr;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            wr_data <= ref_in;
        end
    end

    assign block_end = (addr == `ME_SRAM_DEPTH - 1);

    // --------------------------------------------------
    // Bank rotation and line FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            written   <= 4'b0001;
            block_cnt <= '0;
            state     <= FILL;
            next_line <= 1'b0;
        end else if (en) begin
            next_line <= 1'b0;
            if (block_end) begin
                case (state)
                    FILL: begin
                        written   <= {written[2:0], written[3]};
                        block_cnt <= block_cnt + 8'd1;
                        if (block_cnt == 8'd2) begin
                            state <= RUN;
                        end
                    end
                    RUN: begin
                        // Keep rotating so the gap block still reads the last three
                        written   <= {written[2:0], written[3]};
                        block_cnt <= block_cnt + 8'd1;
                        if (block_cnt == `ME_BLOCKS_PER_LINE - 1) begin
                            state <= LINE_GAP;
                        end
                    end
                    default: begin
                        written   <= 4'b0001;
                        block_cnt <= '0;
                        state     <= FILL;
                        next_line <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Read select changes only at a row-0 boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel <= '0;
        end else if (en && addr == '0) begin
            rd_sel <= written;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sram_ready <= 1'b0;
        end else if (en) begin
            if (next_line) begin
                sram_ready <= 1'b0;
            end else if (state == RUN && written == 4'b1000) begin
                sram_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_block_q <= 1'b0;
        end else if (en) begin
            next_block_q <= sram_ready && (addr_cnt == `ME_NEXT_BLOCK_OFFSET);
        end
    end

    assign next_block = next_block_q & en;

    for (genvar j = 0; j < 4; j++) begin : g_bank
        ref_sram_bank u_bank (
            .clk (clk),
            .me  (en),
            .we  (written[j] && state != LINE_GAP),
            .adr (addr),
            .d   (wr_data),
            .q   (q[j])
        );
    end

    // Oldest block first, newest contributes its upper 7 pixels
    always_comb begin
        window.valid = sram_ready & en;
        window.row   = rd_row;
        case (rd_sel)
            4'b0001: window.pixels = {q[1], q[2], q[3][0:6]};
            4'b0010: window.pixels = {q[2], q[3], q[0][0:6]};
            4'b0100: window.pixels = {q[3], q[0], q[1][0:6]};
            4'b1000: window.pixels = {q[0], q[1], q[2][0:6]};
            default: window.pixels = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/cur_block_buffer.sv
/*
 * Current 8x8 block, written over Wishbone in 32-bit halves.
 * Rows are read combinationally by the SAD unit.
 */

`timescale 1ns/10ps
`default_nettype none

`include "me_params.svh"

module cur_block_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  logic [3:0]        wr_addr,
    input  logic [31:0]       wr_data,
    input  logic [2:0]        row_sel,
    output me_pkg::ref_word_t row
);

    import me_pkg::*;

    ref_word_t rows [`ME_BLOCK_ROWS];

    // Odd address holds pixels 0 to 3, even address pixels 4 to 7
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ME_BLOCK_ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (wr_en) begin
            if (wr_addr[0]) begin
                rows[wr_addr[3:1]][0:3] <= wr_data;
            end else begin
                rows[wr_addr[3:1]][4:7] <= wr_data;
            end
        end
    end

    assign row = rows[row_sel];

endmodule

`default_nettype wire

//--- src/sad_unit.sv
/*
 * Horizontal SAD search over the first 8 window rows.
 * Keeps 16 running sums and reports the lowest one with its offset.
 */

`timescale 1ns/10ps
`default_nettype none

`include "me_params.svh"

module sad_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  me_pkg::ref_window_t window,
    input  me_pkg::ref_word_t   cur_row,
    output logic [2:0]          row_sel,
    output me_pkg::sad_result_t result
);

    import me_pkg::*;

    sad_t       row_sad [`ME_SEARCH_RANGE];
    sad_t       sums [`ME_SEARCH_RANGE];
    sad_t       best_sad;
    logic [3:0] best_idx;
    logic       row_hit;
    logic       last_row;
    logic       done_q;
    logic [3:0] best_dx_q;
    sad_t       min_sad_q;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    assign row_sel = window.row[2:0];
    assign row_hit = window.valid && (window.row < `ME_BLOCK_ROWS);

    // SAD of this row at each offset
    always_comb begin
        for (int dx = 0; dx < `ME_SEARCH_RANGE; dx++) begin
            row_sad[dx] = '0;
            for (int i = 0; i < 8; i++) begin
                row_sad[dx] = row_sad[dx] + abs_diff(cur_row[i], window.pixels[dx + i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && row_hit) begin
            for (int dx = 0; dx < `ME_SEARCH_RANGE; dx++) begin
                sums[dx] <= (window.row == '0) ? row_sad[dx] : sums[dx] + row_sad[dx];
            end
        end
    end

    // Strict compare keeps the lowest dx on a tie
    always_comb begin
        best_sad = sums[0];
        best_idx = '0;
        for (int dx = 1; dx < `ME_SEARCH_RANGE; dx++) begin
            if (sums[dx] < best_sad) begin
                best_sad = sums[dx];
                best_idx = 4'(dx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_row <= 1'b0;
            done_q   <= 1'b0;
        end else if (en) begin
            last_row <= row_hit && (window.row == `ME_BLOCK_ROWS - 1);
            done_q   <= last_row;
        end
    end

    always_ff @(posedge clk) begin
        if (en && last_row) begin
            best_dx_q <= best_idx;
            min_sad_q <= best_sad;
        end
    end

    assign result.best_dx = best_dx_q;
    assign result.min_sad = min_sad_q;
    assign result.done    = done_q & en;

endmodule

`default_nettype wire

//--- src/me_wb_regs.sv
/*
 * Wishbone classic slave for control and readout.
 * Forwards current-block writes and holds the latest search result.
 */

`timescale 1ns/10ps
`default_nettype none

module me_wb_regs (
    input  logic                clk,
    input  logic                rst,
    input  me_pkg::wb_req_t     wb_req,
    output me_pkg::wb_rsp_t     wb_rsp,
    input  me_pkg::sad_result_t result,
    input  logic                sram_ready,
    output logic                cur_wr_en,
    output logic [3:0]          cur_wr_addr,
    output logic [31:0]         cur_wr_data
);

    import me_pkg::*;

    logic        req_active;
    logic        ack_q;
    logic [31:0] rd_mux;
    logic [31:0] rd_data;
    logic [3:0]  best_dx_q;
    sad_t        min_sad_q;
    logic [7:0]  result_cnt;

    assign req_active = wb_req.cyc && wb_req.stb;

    // Single-cycle ack, one cycle after the request shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_active && !ack_q;
        end
    end

    always_comb begin
        case (wb_req.adr)
            5'd16:   rd_mux = {16'd0, result_cnt, 7'd0, sram_ready};
            5'd17:   rd_mux = {28'd0, best_dx_q};
            5'd18:   rd_mux = {18'd0, min_sad_q};
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_active && !ack_q) begin
            rd_data <= rd_mux;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_data;

    // Block writes land on the edge that completes the ack
    assign cur_wr_en   = req_active && wb_req.we && ack_q && !wb_req.adr[4];
    assign cur_wr_addr = wb_req.adr[3:0];
    assign cur_wr_data = wb_req.dat;

    always_ff @(posedge clk) begin
        if (rst) begin
            best_dx_q  <= '0;
            min_sad_q  <= '0;
            result_cnt <= '0;
        end else if (result.done) begin
            best_dx_q  <= result.best_dx;
            min_sad_q  <= result.min_sad;
            result_cnt <= result_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

//--- src/me_top.sv
/*
 * Top of the horizontal motion-estimation slice.
 * Reference words stream in on ref_in; control and results go over Wishbone.
 */

`timescale 1ns/10ps
`default_nettype none

module me_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  me_pkg::ref_word_t ref_in,
    input  me_pkg::wb_req_t   wb_req,
    output me_pkg::wb_rsp_t   wb_rsp,
    output logic              sram_ready,
    output logic              next_block
);

    import me_pkg::*;

    ref_window_t window;
    ref_word_t   cur_row;
    logic [2:0]  row_sel;
    sad_result_t result;
    logic        cur_wr_en;
    logic [3:0]  cur_wr_addr;
    logic [31:0] cur_wr_data;

    ref_window_buffer u_ref_buf (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .ref_in     (ref_in),
        .window     (window),
        .sram_ready (sram_ready),
        .next_block (next_block)
    );

    cur_block_buffer u_cur_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (cur_wr_en),
        .wr_addr (cur_wr_addr),
        .wr_data (cur_wr_data),
        .row_sel (row_sel),
        .row     (cur_row)
    );

    sad_unit u_sad (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .window  (window),
        .cur_row (cur_row),
        .row_sel (row_sel),
        .result  (result)
    );

    me_wb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .result      (result),
        .sram_ready  (sram_ready),
        .cur_wr_en   (cur_wr_en),
        .cur_wr_addr (cur_wr_addr),
        .cur_wr_data (cur_wr_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_me_top.sv
/*
 * Self-checking testbench for the motion-estimation slice.
 * Streams two reference lines with random stalls, models the four banks
 * and checks every search result read back over Wishbone.
 */

`timescale 1ns/10ps
`default_nettype none

`include "me_params.svh"

module tb_me_top;

    import me_pkg::*;

    localparam int depth        = `ME_SRAM_DEPTH;
    localparam int line_words   = (`ME_BLOCKS_PER_LINE + 1) * `ME_SRAM_DEPTH;
    localparam int first_window = 3;
    localparam int windows      = `ME_BLOCKS_PER_LINE - first_window + 1;
    localparam int total_words  = 2 * line_words + 4;
    localparam int ack_limit    = 8;
    localparam int planted_dx   = 5;

    logic        clk = 1'b0;
    logic        rst;
    logic        en;
    ref_word_t   ref_in;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        sram_ready;
    logic        next_block;

    logic [63:0] bank_model [4][depth];
    logic [7:0]  cur_model [8][8];
    integer      seed;
    int          errors;
    int          checks;
    int          words_sent;
    int          results_seen;
    int          pulses;
    bit          match_pending;

    me_top DUT (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .ref_in     (ref_in),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .sram_ready (sram_ready),
        .next_block (next_block)
    );

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // Pixel k of window row r while bank j is written
    function automatic logic [7:0] window_pixel(input int j, input int r, input int k);
        int bank;
        int pix;
        bank = (j + 1 + k / 8) % 4;
        pix  = k % 8;
        return bank_model[bank][r][63 - 8 * pix -: 8];
    endfunction

    function automatic logic [17:0] best_match(input int n);
        int sad;
        int diff;
        int best_sad;
        int best_dx;
        best_sad = 1 << 20;
        best_dx  = 0;
        for (int dx = 0; dx < `ME_SEARCH_RANGE; dx++) begin
            sad = 0;
            for (int r = 0; r < `ME_BLOCK_ROWS; r++) begin
                for (int i = 0; i < 8; i++) begin
                    diff = int'(cur_model[r][i]) - int'(window_pixel(n % 4, r, dx + i));
                    sad += (diff < 0) ? -diff : diff;
                end
            end
            // First minimum wins on a tie
            if (sad < best_sad) begin
                best_sad = sad;
                best_dx  = dx;
            end
        end
        return {best_dx[3:0], best_sad[13:0]};
    endfunction

    // State seen while word w is driven follows the write of word w-2
    function automatic bit ready_expected(input int w);
        if (w < 2) begin
            return 1'b0;
        end
        return ((w - 2) % line_words) >= first_window * depth;
    endfunction

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic bus_access(input bit write, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        en          = 1'b0;
        wb_req.cyc  = 1'b1;
        wb_req.stb  = 1'b1;
        wb_req.we   = write;
        wb_req.adr  = addr;
        wb_req.dat  = wdata;
        @(negedge clk);
        waited = 1;
        while (wb_rsp.ack !== 1'b1 && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (wb_rsp.ack !== 1'b1) begin
            errors++;
            $display("No Wishbone ack within %0d cycles at address %0d", ack_limit, addr);
        end
        rdata = wb_rsp.dat;
        // Cycle ends on the edge that sees ack
        @(negedge clk);
        wb_req = '0;
    endtask

    task automatic load_cur_block();
        logic [31:0] unused;
        for (int r = 0; r < 8; r++) begin
            bus_access(1'b1, 5'(2 * r + 1),
                       {cur_model[r][0], cur_model[r][1], cur_model[r][2], cur_model[r][3]},
                       unused);
            bus_access(1'b1, 5'(2 * r),
                       {cur_model[r][4], cur_model[r][5], cur_model[r][6], cur_model[r][7]},
                       unused);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            en     = 1'b0;
            ref_in = {$random(seed), $random(seed)};
        end
    endtask

    task automatic push_word();
        logic [63:0] word;
        int          pos;
        int          blk;
        int          adr;
        word = {$random(seed), $random(seed)};
        pos  = words_sent % line_words;
        blk  = pos / depth;
        adr  = pos % depth;
        // Gap block writes nothing
        if (blk < `ME_BLOCKS_PER_LINE) begin
            bank_model[blk % 4][adr] = word;
        end
        @(negedge clk);
        en     = 1'b1;
        ref_in = word;
        if (adr == 0) begin
            pulses = 0;
        end
        #1;
        if (next_block === 1'b1) begin
            pulses++;
        end
        check($sformatf("sram_ready at word %0d", words_sent), ready_expected(words_sent),
              sram_ready);
        if (adr == depth - 1) begin
            check($sformatf("next_block pulses in block %0d", blk),
                  (blk >= first_window) ? 1 : 0, pulses);
            check($sformatf("results by end of word %0d", words_sent),
                  (words_sent / line_words) * windows
                  + ((blk >= first_window) ? blk - first_window + 1 : 0), results_seen);
        end
        words_sent++;
    endtask

    // Current block equal to window n at planted_dx
    task automatic plant_match(input int n);
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < 8; i++) begin
                cur_model[r][i] = window_pixel(n % 4, r, planted_dx + i);
            end
        end
        load_cur_block();
        match_pending = 1'b1;
    endtask

    task automatic poll_results();
        logic [31:0] status;
        logic [31:0] dx_rd;
        logic [31:0] sad_rd;
        logic [31:0] again;
        logic [17:0] expected;
        int          line;
        int          blk;
        bus_access(1'b0, 5'd16, '0, status);
        check("status ready bit", ready_expected(words_sent), status[0]);
        if (status[15:8] != 8'(results_seen)) begin
            check("result count step", results_seen + 1, status[15:8]);
            results_seen = status[15:8];
            line     = (words_sent - 1) / line_words;
            blk      = ((words_sent - 1) % line_words) / depth;
            expected = best_match(blk);
            bus_access(1'b0, 5'd17, '0, dx_rd);
            bus_access(1'b0, 5'd18, '0, sad_rd);
            if (blk < first_window) begin
                errors++;
                $display("Result arrived in block %0d of line %0d before any full window",
                         blk, line);
            end else begin
                check($sformatf("best_dx line %0d block %0d", line, blk),
                      {28'd0, expected[17:14]}, dx_rd);
                check($sformatf("min_sad line %0d block %0d", line, blk),
                      {18'd0, expected[13:0]}, sad_rd);
            end
            if (match_pending) begin
                check("planted best_dx", planted_dx, dx_rd);
                check("planted min_sad", 0, sad_rd);
                match_pending = 1'b0;
            end
            // Nothing may move while en stays low
            idle_cycles(1 + ($random(seed) & 7));
            bus_access(1'b0, 5'd16, '0, again);
            check("status held", status, again);
            bus_access(1'b0, 5'd17, '0, again);
            check("best_dx held", dx_rd, again);
            bus_access(1'b0, 5'd18, '0, again);
            check("min_sad held", sad_rd, again);
            if (line == 1 && blk == first_window) begin
                plant_match(blk + 1);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int          burst;
        logic [31:0] status;
        seed          = 26;
        errors        = 0;
        checks        = 0;
        words_sent    = 0;
        results_seen  = 0;
        pulses        = 0;
        match_pending = 1'b0;
        rst           = 1'b1;
        en            = 1'b0;
        ref_in        = '0;
        wb_req        = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        bus_access(1'b0, 5'd16, '0, status);
        check("status after reset", 0, status);
        check("sram_ready after reset", 0, sram_ready);
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < 8; i++) begin
                cur_model[r][i] = 8'($random(seed));
            end
        end
        load_cur_block();

        // Two full lines plus the start of a third
        while (words_sent < total_words) begin
            burst = 1 + ($random(seed) & 3);
            for (int i = 0; i < burst && words_sent < total_words; i++) begin
                push_word();
            end
            poll_results();
            if (($random(seed) & 3) == 0) begin
                idle_cycles(1 + ($random(seed) & 7));
            end
        end
        check("results over two lines", 2 * windows, results_seen);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/me_pkg.sv
src/ref_sram_bank.sv
src/ref_window_buffer.sv
src/cur_block_buffer.sv
src/sad_unit.sv
src/me_wb_regs.sv
src/me_top.sv
testbench/tb_me_top.sv

//--- Bender.yml
package:
  name: me_slice

sources:
  - include_dirs:
      - src
    files:
      - src/me_pkg.sv
      - src/ref_sram_bank.sv
      - src/ref_window_buffer.sv
      - src/cur_block_buffer.sv
      - src/sad_unit.sv
      - src/me_wb_regs.sv
      - src/me_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_me_top.sv
